// ==== aggregation_match_evaluator.sv ====
`include "node_params.svh"

module aggregation_match_evaluator import sink_scan_pkg::*; (
	input  logic                          clock,
	input  logic                          nrst,
	input  logic                          start,
	input  logic [`WORD_WIDTH-1:0]        my_cluster_id,
	mem_read_if.consumer                  rd,
	output logic                          halt,
	output logic                          for_aggregation,
	output logic [$clog2(`NUM_NEIGHBORS)-1:0] matched_neighbor,
	output logic                          done
);

	logic [`WORD_WIDTH-1:0] neighbor_id;   // current neighbor
	logic [`WORD_WIDTH-1:0] cluster_id;    // its cluster
	logic                   busy;          // scan in progress
	logic                   words_ready;   // cluster word seen since start
	logic                   matched;
	logic                   accept;
	logic                   sink_hit;

	assign accept = start && !busy;

	// sink equals the neighbor and the neighbor sits in another cluster
	assign sink_hit = (rd.rsp_data == neighbor_id) && (cluster_id != my_cluster_id);

	assign halt            = matched;
	assign for_aggregation = matched;

	always_ff @(posedge clock) begin
		if (rd.rsp_valid) begin
			case (rd.rsp_tag.kind)
				FETCH_NEIGHBOR: neighbor_id <= rd.rsp_data;
				FETCH_CLUSTER:  cluster_id  <= rd.rsp_data;
				default:        ;   // sinks are compared, not stored
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			busy             <= 1'b0;
			words_ready      <= 1'b0;
			matched          <= 1'b0;
			done             <= 1'b0;
			matched_neighbor <= '0;
		end else if (accept) begin
			busy             <= 1'b1;
			words_ready      <= 1'b0;
			matched          <= 1'b0;
			done             <= 1'b0;
			matched_neighbor <= '0;
		end else if (busy && rd.rsp_valid) begin
			case (rd.rsp_tag.kind)
				FETCH_CLUSTER: words_ready <= 1'b1;
				FETCH_SINK: begin
					// a sink left over from a halted scan arrives before any cluster word
					if (words_ready) begin
						if (sink_hit) begin
							matched          <= 1'b1;
							matched_neighbor <= rd.rsp_tag.neighbor_idx;
							done             <= 1'b1;
							busy             <= 1'b0;   // later responses ignored
						end else if (rd.rsp_tag.last) begin
							done <= 1'b1;   // no neighbor qualified
							busy <= 1'b0;
						end
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== filelist.f ====
+incdir+.
sink_scan_pkg.sv
mem_read_if.sv
scan_address_sequencer.sv
node_memory.sv
aggregation_match_evaluator.sv
sink_scan_top.sv
sink_scan_tb.sv

// ==== mem_read_if.sv ====
`include "node_params.svh"

interface mem_read_if import sink_scan_pkg::*; ();

	logic                   req_valid;   // one read this cycle
	logic [`ADDR_WIDTH-1:0] req_addr;    // address of the low byte
	read_tag_t              req_tag;

	logic                   rsp_valid;   // follows req_valid by one cycle
	logic [`WORD_WIDTH-1:0] rsp_data;
	read_tag_t              rsp_tag;     // same tag as the request

	modport issuer (
		output req_valid,
		output req_addr,
		output req_tag
	);

	modport server (
		input  req_valid,
		input  req_addr,
		input  req_tag,
		output rsp_valid,
		output rsp_data,
		output rsp_tag
	);

	modport consumer (
		input  rsp_valid,
		input  rsp_data,
		input  rsp_tag
	);

endinterface

// ==== node_memory.sv ====
`include "node_params.svh"

module node_memory (
	input  logic                   clock,
	input  logic                   nrst,
	input  logic                   wr_en,
	input  logic [`ADDR_WIDTH-1:0] wr_addr,
	input  logic [`BYTE_WIDTH-1:0] wr_data,
	mem_read_if.server             rd
);

	logic [`BYTE_WIDTH-1:0] mem [`MEM_DEPTH];
	logic [`ADDR_WIDTH-1:0] hi_addr;   // high byte of the word

	assign hi_addr = rd.req_addr + 1'b1;   // wraps at the top of memory

	// table loading, one byte per cycle
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			rd.rsp_valid <= 1'b0;
		end else begin
			rd.rsp_valid <= rd.req_valid;
		end
	end

	// little-endian word, low byte at req_addr
	always_ff @(posedge clock) begin
		if (rd.req_valid) begin
			rd.rsp_data <= {mem[hi_addr], mem[rd.req_addr]};
			rd.rsp_tag  <= rd.req_tag;   // passed through unchanged
		end
	end

endmodule

// ==== node_params.svh ====
`ifndef NODE_PARAMS_SVH
`define NODE_PARAMS_SVH

// node memory geometry
`define MEM_DEPTH     1024    // bytes
`define ADDR_WIDTH    10      // byte address bits
`define BYTE_WIDTH    8
`define WORD_WIDTH    16      // table word, two bytes little-endian

// table layout in node memory
`define SINK_BASE     'h08    // known sinks
`define NEIGHBOR_BASE 'h48    // neighbor ids
`define CLUSTER_BASE  'hC8    // cluster id of each neighbor

// table lengths in words
`define NUM_SINKS     16
`define NUM_NEIGHBORS 64

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sink scan testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module sink_scan_tb -f filelist.f -o sink_scan_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sink_scan_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$log"; then
	exit 0
else
	exit 1
fi

// ==== scan_address_sequencer.sv ====
`include "node_params.svh"

module scan_address_sequencer import sink_scan_pkg::*; (
	input  logic       clock,
	input  logic       nrst,
	input  logic       start,
	input  logic       halt,
	mem_read_if.issuer rd
);

	localparam int NBR_W  = $clog2(`NUM_NEIGHBORS);
	localparam int SINK_W = $clog2(`NUM_SINKS);

	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	logic              running;    // issuing one read per cycle
	logic              draining;   // final read in flight, result not out yet
	fetch_kind_e       phase;      // kind of the read issued this cycle
	logic [NBR_W-1:0]  nbr_idx;
	logic [SINK_W-1:0] sink_idx;
	logic              last_sink;
	logic              last_req;
	logic              accept;

	assign last_sink = (phase == FETCH_SINK) && (sink_idx == SINK_W'(`NUM_SINKS - 1));
	assign last_req  = last_sink && (nbr_idx == NBR_W'(`NUM_NEIGHBORS - 1));

	// a halted scan counts as finished, since the evaluator has its result
	assign accept = start && ((!running && !draining) || halt);

	assign rd.req_valid = running;

	always_comb begin
		case (phase)
			FETCH_NEIGHBOR: rd.req_addr = addr_t'(`NEIGHBOR_BASE) + addr_t'({nbr_idx, 1'b0});
			FETCH_CLUSTER:  rd.req_addr = addr_t'(`CLUSTER_BASE) + addr_t'({nbr_idx, 1'b0});
			default:        rd.req_addr = addr_t'(`SINK_BASE) + addr_t'({sink_idx, 1'b0});
		endcase
	end

	always_comb begin
		rd.req_tag.kind         = phase;
		rd.req_tag.neighbor_idx = nbr_idx;
		rd.req_tag.last         = last_req;
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			running  <= 1'b0;
			draining <= 1'b0;
			phase    <= FETCH_NEIGHBOR;
			nbr_idx  <= '0;
			sink_idx <= '0;
		end else begin
			draining <= 1'b0;
			if (accept) begin
				running  <= 1'b1;
				phase    <= FETCH_NEIGHBOR;   // restart at neighbor 0
				nbr_idx  <= '0;
				sink_idx <= '0;
			end else if (running) begin
				if (halt) begin
					running <= 1'b0;   // match found downstream
				end else begin
					case (phase)
						FETCH_NEIGHBOR: phase <= FETCH_CLUSTER;
						FETCH_CLUSTER:  phase <= FETCH_SINK;
						default: begin
							sink_idx <= sink_idx + 1'b1;   // wraps to 0 after the last sink
							if (last_sink) begin
								phase   <= FETCH_NEIGHBOR;
								nbr_idx <= nbr_idx + 1'b1;
							end
							if (last_req) begin
								running  <= 1'b0;
								draining <= 1'b1;   // wait for the last response
							end
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== sink_scan_pkg.sv ====
`include "node_params.svh"

package sink_scan_pkg;

	// what a returned word holds
	typedef enum logic [1:0] {
		FETCH_NEIGHBOR = 2'd0,   // neighbor id
		FETCH_CLUSTER  = 2'd1,   // that neighbor's cluster id
		FETCH_SINK     = 2'd2    // one known sink
	} fetch_kind_e;

	// travels with each read so the evaluator can interpret the data
	typedef struct packed {
		fetch_kind_e                        kind;
		logic [$clog2(`NUM_NEIGHBORS)-1:0] neighbor_idx;   // neighbor being checked
		logic                               last;           // final sink of final neighbor
	} read_tag_t;

endpackage

// ==== sink_scan_tb.sv ====
`include "node_params.svh"

module sink_scan_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NBR_W       = $clog2(`NUM_NEIGHBORS);
	localparam int CYCLE_LIMIT = 10000;
	localparam int SCAN_BOUND  = `NUM_NEIGHBORS * (`NUM_SINKS + 2) + 10;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	logic                   clock;
	logic                   nrst;
	logic                   start;
	logic [`WORD_WIDTH-1:0] my_cluster_id;
	logic                   wr_en;
	logic [`ADDR_WIDTH-1:0] wr_addr;
	logic [`BYTE_WIDTH-1:0] wr_data;
	logic                   for_aggregation;
	logic [NBR_W-1:0]       matched_neighbor;
	logic                   done;

	logic [`WORD_WIDTH-1:0] sinks [`NUM_SINKS];       // model copy of the tables
	logic [`WORD_WIDTH-1:0] nbrs  [`NUM_NEIGHBORS];
	logic [`WORD_WIDTH-1:0] clus  [`NUM_NEIGHBORS];
	logic [`WORD_WIDTH-1:0] cluster_self;             // own cluster as the model sees it
	logic                   exp_agg;
	logic [NBR_W-1:0]       exp_idx;

	int          cycle_count = 0;
	int          errors = 0;
	int          errors_before;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          scan_start;

	sink_scan_top DUT (
		.clock            (clock),
		.nrst             (nrst),
		.start            (start),
		.my_cluster_id    (my_cluster_id),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.for_aggregation  (for_aggregation),
		.matched_neighbor (matched_neighbor),
		.done             (done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: done never rose within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	assert property (@(posedge clock) disable iff (!nrst) for_aggregation |-> done)
		else begin
			errors++;
			$display("Error: %0t: for_aggregation high while done is low", $time);
		end

	assert property (@(posedge clock) disable iff (!nrst) done && !start |=> done)
		else begin
			errors++;
			$display("Error: %0t: done fell without a start", $time);
		end

	assert property (@(posedge clock) disable iff (!nrst) done && start |=> !done)
		else begin
			errors++;
			$display("Error: %0t: start after done did not clear done", $time);
		end

	assert property (@(posedge clock) disable iff (!nrst)
		$rose(done) |-> (for_aggregation == exp_agg) && (matched_neighbor == exp_idx))
		else begin
			errors++;
			$display("Error: %0t: result agg=%0b idx=%0d, expected agg=%0b idx=%0d",
				$time, for_aggregation, matched_neighbor, exp_agg, exp_idx);
		end

	task automatic write_word(input addr_t addr, input logic [`WORD_WIDTH-1:0] data);
		@(posedge clock);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data[7:0];   // low byte first
		@(posedge clock);
		wr_addr <= addr + 1'b1;
		wr_data <= data[15:8];
	endtask

	task automatic load_tables();
		for (int i = 0; i < `NUM_SINKS; i++) begin
			write_word(addr_t'(`SINK_BASE + 2 * i), sinks[i]);
		end
		for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
			write_word(addr_t'(`NEIGHBOR_BASE + 2 * i), nbrs[i]);
			write_word(addr_t'(`CLUSTER_BASE + 2 * i), clus[i]);
		end
		@(posedge clock);
		wr_en <= 1'b0;
	endtask

	// first neighbor in ascending order with a known sink id and a foreign cluster
	task automatic compute_expected();
		exp_agg = 1'b0;
		exp_idx = '0;
		for (int n = 0; n < `NUM_NEIGHBORS; n++) begin
			for (int s = 0; s < `NUM_SINKS; s++) begin
				if (!exp_agg && nbrs[n] == sinks[s] && clus[n] != cluster_self) begin
					exp_agg = 1'b1;
					exp_idx = NBR_W'(n);
				end
			end
		end
	endtask

	task automatic fill_distinct_tables();
		for (int i = 0; i < `NUM_SINKS; i++) begin
			sinks[i] = 16'h5000 + 16'(i);
		end
		for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
			nbrs[i] = 16'h9000 + 16'(i);   // never a sink
			clus[i] = 16'($urandom);
		end
	endtask

	task automatic pulse_start();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic wait_done();
		do begin
			@(posedge clock);
		end while (!done);
		@(posedge clock);   // edge checks of the rise have reported by now
	endtask

	task automatic report_test(input string name);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic check_scan(input string name);
		errors_before = errors;
		load_tables();
		compute_expected();
		pulse_start();
		wait_done();
		report_test(name);
	endtask

	initial begin
		nrst          = 1'b0;
		start         = 1'b0;
		wr_en         = 1'b0;
		wr_addr       = '0;
		wr_data       = '0;
		cluster_self  = 16'h0c1a;
		my_cluster_id = cluster_self;
		exp_agg       = 1'b0;
		exp_idx       = '0;
		void'($urandom(32'h6a4c_13c9));
		repeat (2) @(posedge clock);
		nrst <= 1'b1;
		@(posedge clock);

		errors_before = errors;
		assert (!done && !for_aggregation) else begin
			errors++;
			$display("Error: %0t: done or for_aggregation high after reset", $time);
		end
		report_test("reset state");

		fill_distinct_tables();
		check_scan("no matching sink");

		fill_distinct_tables();
		nbrs[37] = sinks[5];
		clus[37] = cluster_self ^ 16'h00ff;   // foreign cluster
		check_scan("single foreign match");

		fill_distinct_tables();
		nbrs[20] = sinks[3];
		clus[20] = cluster_self;   // same cluster, no aggregation
		check_scan("match in own cluster");

		for (int i = 0; i < `NUM_SINKS; i++) begin
			sinks[i] = 16'($urandom);
		end
		for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
			nbrs[i] = 16'($urandom);
			clus[i] = 16'($urandom);
		end
		nbrs[12] = sinks[9];
		clus[12] = cluster_self;
		nbrs[29] = sinks[0];
		clus[29] = ~cluster_self;
		nbrs[47] = sinks[15];
		clus[47] = cluster_self + 16'd3;
		check_scan("random tables, lowest match");

		errors_before = errors;
		fill_distinct_tables();
		load_tables();
		compute_expected();
		pulse_start();
		scan_start = cycle_count;
		repeat (300) @(posedge clock);
		pulse_start();   // must not restart the scan
		wait_done();
		assert (cycle_count - scan_start <= SCAN_BOUND) else begin
			errors++;
			$display("Error: %0t: scan took %0d cycles, the start during the scan restarted it",
				$time, cycle_count - scan_start);
		end
		fill_distinct_tables();
		nbrs[5] = sinks[11];
		clus[5] = ~cluster_self;
		load_tables();
		compute_expected();
		pulse_start();
		wait_done();
		report_test("start during scan and restart");

		$display("tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
			errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== sink_scan_top.sv ====
`include "node_params.svh"

module sink_scan_top (
	input  logic                              clock,
	input  logic                              nrst,
	input  logic                              start,
	input  logic [`WORD_WIDTH-1:0]            my_cluster_id,
	input  logic                              wr_en,
	input  logic [`ADDR_WIDTH-1:0]            wr_addr,
	input  logic [`BYTE_WIDTH-1:0]            wr_data,
	output logic                              for_aggregation,
	output logic [$clog2(`NUM_NEIGHBORS)-1:0] matched_neighbor,
	output logic                              done
);

	logic halt;   // evaluator back to sequencer

	// shared by all three stages
	mem_read_if rd_link ();

	scan_address_sequencer u_sequencer (
		.clock (clock),
		.nrst  (nrst),
		.start (start),
		.halt  (halt),
		.rd    (rd_link.issuer)
	);

	node_memory u_memory (
		.clock   (clock),
		.nrst    (nrst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd      (rd_link.server)
	);

	aggregation_match_evaluator u_evaluator (
		.clock            (clock),
		.nrst             (nrst),
		.start            (start),
		.my_cluster_id    (my_cluster_id),
		.rd               (rd_link.consumer),
		.halt             (halt),
		.for_aggregation  (for_aggregation),
		.matched_neighbor (matched_neighbor),
		.done             (done)
	);

endmodule
